// File: cpu.sv
// Pipelined core top level
// Fetch, decode, execute and memory stages, register file, hazard unit
`timescale 1ns/10ps
`default_nettype none

module cpu import isaPkg::*, pipePkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] pc,
    output logic [31:0] brPc,
    output logic [31:0] brAddr,
    output logic [31:0] brWData,
    output logic [3:0]  brWe,
    input  logic [31:0] brRData,
    output logic [31:0] imPc,
    input  logic [31:0] imCode
);

    ifIdRegT                 ifId;
    idExRegT                 idEx;
    exMemRegT                exMem;
    memWbRegT                wb;
    busReqT                  busReq;
    logic                    stall;
    logic                    bubble;
    logic                    branchTaken;
    logic [31:0]             branchTarget;
    logic [RegAddrWidth-1:0] rdAddr1;
    logic [RegAddrWidth-1:0] rdAddr2;
    logic [31:0]             rdData1;
    logic [31:0]             rdData2;
    timeT                    useRs;
    timeT                    useRt;

    fetchStage uFetch (
        .clk(clk), .reset(reset), .stall(stall),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .imPc(imPc), .imCode(imCode), .ifId(ifId)
    );

    decodeStage uDecode (
        .clk(clk), .reset(reset), .stall(stall), .bubble(bubble), .ifId(ifId),
        .rdAddr1(rdAddr1), .rdAddr2(rdAddr2), .rdData1(rdData1), .rdData2(rdData2),
        .exFwd(idEx), .memFwd(exMem),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .useRs(useRs), .useRt(useRt), .idEx(idEx)
    );

    registerFile uRegs (
        .clk(clk), .reset(reset), .rdAddr1(rdAddr1), .rdAddr2(rdAddr2),
        .rdData1(rdData1), .rdData2(rdData2), .wb(wb)
    );

    executeStage uExecute (
        .clk(clk), .reset(reset), .idEx(idEx), .memFwd(exMem), .wb(wb), .exMem(exMem)
    );

    memoryStage uMemory (
        .clk(clk), .reset(reset), .exMem(exMem), .wbFwd(wb),
        .busReq(busReq), .brRData(brRData), .wb(wb)
    );

    hazardControl uHazard (
        .rsAddr(rdAddr1), .rtAddr(rdAddr2), .useRs(useRs), .useRt(useRt),
        .idEx(idEx), .exMem(exMem), .stall(stall), .bubble(bubble)
    );

    // Bridge side of the data bus
    assign pc      = exMem.pc;
    assign brPc    = busReq.pc;
    assign brAddr  = busReq.addr;
    assign brWData = busReq.wData;
    assign brWe    = busReq.byteEn;

endmodule

`default_nettype wire

// File: cpu_testdata.txt
// First word: number of tests. Each test: name index, program length, record count,
// then the program words, then one line per bus write: address, data, byte enables
00000005
// Test 1, arithmetic and logic
00000001 00000012 00000008
24010005 2402fffd 00221821 ac030100 00222023 ac040104
00222824 ac050108 00223025 ac06010c 0041382a ac070110
00014100 ac080114 34298000 ac090118 3c0a1234 ac0a011c
00000100 00000002 0000000f
00000104 00000008 0000000f
00000108 00000005 0000000f
0000010c fffffffd 0000000f
00000110 00000001 0000000f
00000114 00000050 0000000f
00000118 00008005 0000000f
0000011c 12340000 0000000f
// Test 2, dependent chains
00000002 00000009 00000003
24010001 00211021 00411821 00622021 00812823
ac050200 ac040204 24a60010 ac060208
00000200 00000004 0000000f
00000204 00000005 0000000f
00000208 00000014 0000000f
// Test 3, load-use with sign and zero extension, load then branch
00000003 00000015 00000008
3c0180f2 34217f93 ac010300 8c020300 24430001 ac030304 80040300
ac040308 90050302 ac05030c 84060302 ac060310 94070302 ac070314
84080300 ac080318 8c090300 11210002 240a0011 240a0022 ac0a031c
00000300 80f27f93 0000000f
00000304 80f27f94 0000000f
00000308 ffffff93 0000000f
0000030c 000000f2 0000000f
00000310 ffff80f2 0000000f
00000314 000080f2 0000000f
00000318 00007f93 0000000f
0000031c 00000011 0000000f
// Test 4, byte and half stores at each offset
00000004 0000000b 00000008
3401cdab a0010400 a0010401 a0010402 a0010403 a4010404
a4010406 8c020400 ac020408 8c030404 ac03040c
00000400 000000ab 00000001
00000401 0000ab00 00000002
00000402 00ab0000 00000004
00000403 ab000000 00000008
00000404 0000cdab 00000003
00000406 cdab0000 0000000c
00000408 abababab 0000000f
0000040c cdabcdab 0000000f
// Test 5, branches, jumps, jal link and jr return
00000005 00000017 00000006
24010007 24020007 10220003 24030001 24030055 24030066 ac030500 14220002
24040002 24840003 ac040504 0c000c11 24050009 ac05050c ac060510 08000c16
24070003 ac1f0508 03e00008 24060077 24060099 24070044 ac070514
00000500 00000001 0000000f
00000504 00000005 0000000f
00000508 00003034 0000000f
0000050c 00000009 0000000f
00000510 00000077 0000000f
00000514 00000003 0000000f

// File: decodeStage.sv
// Instruction decoder with use and produce times
// Operand forwarding, branch compare and jump targets
// Decode/execute pipeline register
`timescale 1ns/10ps
`default_nettype none

module decodeStage import isaPkg::*, pipePkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    bubble,
    input  ifIdRegT                 ifId,
    output logic [RegAddrWidth-1:0] rdAddr1,
    output logic [RegAddrWidth-1:0] rdAddr2,
    input  logic [31:0]             rdData1,
    input  logic [31:0]             rdData2,
    input  idExRegT                 exFwd,
    input  exMemRegT                memFwd,
    output logic                    branchTaken,
    output logic [31:0]             branchTarget,
    output timeT                    useRs,
    output timeT                    useRt,
    output idExRegT                 idEx
);

    opcodeT                    opcode;
    functT                     funct;
    logic [RegAddrWidth-1:0]   rs;
    logic [RegAddrWidth-1:0]   rt;
    logic [RegAddrWidth-1:0]   rd;
    logic [ImmWidth-1:0]       imm16;
    logic [JumpIndexWidth-1:0] jumpIndex;
    logic [31:0]               pcPlus4;
    logic [31:0]               rsVal;
    logic [31:0]               rtVal;
    logic                      signExt;
    logic                      taken;
    idExRegT                   next;

    assign opcode    = opcodeT'(ifId.instr[31 -: OpcodeWidth]);
    assign funct     = functT'(ifId.instr[FunctWidth-1:0]);
    assign rs        = ifId.instr[25 -: RegAddrWidth];
    assign rt        = ifId.instr[20 -: RegAddrWidth];
    assign rd        = ifId.instr[15 -: RegAddrWidth];
    assign imm16     = ifId.instr[ImmWidth-1:0];
    assign jumpIndex = ifId.instr[JumpIndexWidth-1:0];
    assign pcPlus4   = ifId.pc + 32'd4;
    assign rdAddr1   = rs;
    assign rdAddr2   = rt;

    // Youngest producer first; a result not yet ready is replaced later or stalled on
    function automatic logic [31:0] forward(input logic [RegAddrWidth-1:0] addr,
                                            input logic [31:0] regVal);
        if (exFwd.dest != '0 && exFwd.dest == addr) begin
            return exFwd.early;
        end else if (memFwd.dest != '0 && memFwd.dest == addr) begin
            return memFwd.result;
        end
        return regVal;
    endfunction

    always_comb begin
        rsVal        = forward(rs, rdData1);
        rtVal        = forward(rt, rdData2);
        next         = '0;
        next.pc      = ifId.pc;
        next.aluOp   = AluAdd;
        next.opA     = rsVal;
        next.opB     = rtVal;
        next.rs      = rs;
        next.rt      = rt;
        next.shamt   = ifId.instr[10 -: ShamtWidth];
        next.memOp   = MemNone;
        next.tNew    = TimeAlu;
        signExt      = 1'b1;
        taken        = 1'b0;
        branchTarget = pcPlus4 + {{14{imm16[ImmWidth-1]}}, imm16, 2'b00};
        useRs        = UseNone;
        useRt        = UseNone;

        case (opcode)
            OpSpecial: begin
                useRs     = UseAlu;
                useRt     = UseAlu;
                next.dest = rd;
                case (funct)
                    FnAddu: next.aluOp = AluAdd;
                    FnSubu: next.aluOp = AluSub;
                    FnAnd:  next.aluOp = AluAnd;
                    FnOr:   next.aluOp = AluOr;
                    FnSlt:  next.aluOp = AluSlt;
                    FnSll: begin
                        next.aluOp = AluSll;
                        useRs      = UseNone;
                    end
                    FnJr: begin
                        next.dest    = '0;
                        useRs        = UseBranch;
                        useRt        = UseNone;
                        taken        = 1'b1;
                        branchTarget = rsVal;
                    end
                    default: next.dest = '0;
                endcase
            end
            OpJ, OpJal: begin
                taken        = 1'b1;
                branchTarget = {pcPlus4[31:28], jumpIndex, 2'b00};
                if (opcode == OpJal) begin
                    // Link address is known here, so it is ready at once
                    next.dest  = 5'd31;
                    next.early = pcPlus4 + 32'd4;
                    next.tNew  = TimeNow;
                end
            end
            OpBeq, OpBne: begin
                useRs = UseBranch;
                useRt = UseBranch;
                taken = (rsVal == rtVal) ^ (opcode == OpBne);
            end
            OpAddiu, OpOri, OpLui: begin
                useRs       = (opcode == OpLui) ? UseNone : UseAlu;
                signExt     = (opcode == OpAddiu);
                next.immSel = 1'b1;
                next.dest   = rt;
                next.aluOp  = (opcode == OpAddiu) ? AluAdd :
                              (opcode == OpOri) ? AluOr : AluLui;
            end
            OpLw, OpLh, OpLhu, OpLb, OpLbu: begin
                useRs       = UseAlu;
                next.immSel = 1'b1;
                next.dest   = rt;
                next.tNew   = TimeLoad;
                next.memOp  = (opcode == OpLw) ? MemWord :
                              (opcode == OpLh) ? MemHalfS :
                              (opcode == OpLhu) ? MemHalfU :
                              (opcode == OpLb) ? MemByteS : MemByteU;
            end
            OpSw, OpSh, OpSb: begin
                useRs       = UseAlu;
                useRt       = UseStore;
                next.immSel = 1'b1;
                next.store  = 1'b1;
                next.memOp  = (opcode == OpSw) ? MemWord :
                              (opcode == OpSh) ? MemHalfU : MemByteU;
            end
            default: ;
        endcase

        next.imm = signExt ? {{16{imm16[ImmWidth-1]}}, imm16} : {16'h0000, imm16};
    end

    // A stalled branch waits for its operands before redirecting
    assign branchTaken = taken && !stall;

    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            idEx <= '0;
        end else begin
            idEx <= next;
        end
    end

endmodule

`default_nettype wire

// File: executeStage.sv
// ALU with operand forwarding from memory and writeback
// Execute/memory pipeline register
`timescale 1ns/10ps
`default_nettype none

module executeStage import pipePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  idExRegT  idEx,
    input  exMemRegT memFwd,
    input  memWbRegT wb,
    output exMemRegT exMem
);

    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] srcB;
    logic [31:0] aluOut;
    exMemRegT    next;

    function automatic logic [31:0] forward(input logic [4:0] addr,
                                            input logic [31:0] decodeVal);
        if (memFwd.dest != '0 && memFwd.dest == addr) begin
            return memFwd.result;
        end else if (wb.dest != '0 && wb.dest == addr) begin
            return wb.data;
        end
        return decodeVal;
    endfunction

    always_comb begin
        rsVal = forward(idEx.rs, idEx.opA);
        rtVal = forward(idEx.rt, idEx.opB);
        srcB  = idEx.immSel ? idEx.imm : rtVal;

        case (idEx.aluOp)
            AluAdd:  aluOut = rsVal + srcB;
            AluSub:  aluOut = rsVal - srcB;
            AluAnd:  aluOut = rsVal & srcB;
            AluOr:   aluOut = rsVal | srcB;
            AluSlt:  aluOut = {31'd0, $signed(rsVal) < $signed(srcB)};
            AluSll:  aluOut = srcB << idEx.shamt;
            AluLui:  aluOut = {srcB[15:0], 16'h0000};
            default: aluOut = '0;
        endcase

        next.pc        = idEx.pc;
        next.aluResult = aluOut;
        next.storeData = rtVal;
        next.rt        = idEx.rt;
        next.memOp     = idEx.memOp;
        next.store     = idEx.store;
        next.dest      = idEx.dest;
        // jal keeps its link address
        next.result    = (idEx.tNew == TimeNow) ? idEx.early : aluOut;
        next.tNew      = (idEx.tNew == TimeNow) ? TimeNow : idEx.tNew - 2'd1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exMem <= '0;
        end else begin
            exMem <= next;
        end
    end

endmodule

`default_nettype wire

// File: fetchStage.sv
// Program counter with next-address select
// Fetch/decode pipeline register
`timescale 1ns/10ps
`default_nettype none

module fetchStage import isaPkg::*, pipePkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        branchTaken,
    input  logic [31:0] branchTarget,
    output logic [31:0] imPc,
    input  logic [31:0] imCode,
    output ifIdRegT     ifId
);

    logic [31:0] pc;
    logic [31:0] pcNext;

    assign imPc = pc;

    // Decode redirects after the delay slot has been fetched
    assign pcNext = branchTaken ? branchTarget : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc   <= ResetPc;
            ifId <= '0;
        end else if (!stall) begin
            pc         <= pcNext;
            ifId.instr <= imCode;
            ifId.pc    <= pc;
        end
    end

endmodule

`default_nettype wire

// File: hazardControl.sv
// Stall and bubble control from register use and produce times
`timescale 1ns/10ps
`default_nettype none

module hazardControl import isaPkg::*, pipePkg::*; (
    input  logic [RegAddrWidth-1:0] rsAddr,
    input  logic [RegAddrWidth-1:0] rtAddr,
    input  timeT                    useRs,
    input  timeT                    useRt,
    input  idExRegT                 idEx,
    input  exMemRegT                exMem,
    output logic                    stall,
    output logic                    bubble
);

    // Producer result arrives later than the source is needed
    function automatic logic waits(input logic [RegAddrWidth-1:0] src,
                                   input timeT useTime,
                                   input logic [RegAddrWidth-1:0] dest,
                                   input timeT tNew);
        return src != '0 && src == dest && tNew > useTime;
    endfunction

    assign stall = waits(rsAddr, useRs, idEx.dest, idEx.tNew)
                || waits(rtAddr, useRt, idEx.dest, idEx.tNew)
                || waits(rsAddr, useRs, exMem.dest, exMem.tNew)
                || waits(rtAddr, useRt, exMem.dest, exMem.tNew);

    // The held instruction leaves an empty slot behind in execute
    assign bubble = stall;

endmodule

`default_nettype wire

// File: isaPkg.sv
// Instruction field widths of the supported MIPS subset
// Primary opcode and function code encodings, first fetch address
`default_nettype none

package isaPkg;

    localparam int OpcodeWidth = 6;
    localparam int FunctWidth = 6;
    localparam int RegAddrWidth = 5;
    localparam int ShamtWidth = 5;
    localparam int ImmWidth = 16;
    localparam int JumpIndexWidth = 26;

    localparam logic [31:0] ResetPc = 32'h0000_3000;

    // Primary opcodes, bits 31:26
    typedef enum logic [OpcodeWidth-1:0] {
        OpSpecial = 6'h00,
        OpJ       = 6'h02,
        OpJal     = 6'h03,
        OpBeq     = 6'h04,
        OpBne     = 6'h05,
        OpAddiu   = 6'h09,
        OpOri     = 6'h0d,
        OpLui     = 6'h0f,
        OpLb      = 6'h20,
        OpLh      = 6'h21,
        OpLw      = 6'h23,
        OpLbu     = 6'h24,
        OpLhu     = 6'h25,
        OpSb      = 6'h28,
        OpSh      = 6'h29,
        OpSw      = 6'h2b
    } opcodeT;

    // Function codes of the special opcode
    typedef enum logic [FunctWidth-1:0] {
        FnSll  = 6'h00,
        FnJr   = 6'h08,
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnSlt  = 6'h2a
    } functT;

endpackage

`default_nettype wire

// File: memoryStage.sv
// Store lane alignment and byte enables on the data bus
// Load extraction with sign or zero extension
// Memory/writeback pipeline register
`timescale 1ns/10ps
`default_nettype none

module memoryStage import pipePkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  exMemRegT    exMem,
    input  memWbRegT    wbFwd,
    output busReqT      busReq,
    input  logic [31:0] brRData,
    output memWbRegT    wb
);

    logic [31:0] storeVal;
    logic [4:0]  laneShift;
    logic [3:0]  laneMask;
    logic [31:0] loadShift;
    logic [31:0] loadVal;

    always_comb begin
        // Store data may still come from a load now in writeback
        storeVal  = (wbFwd.dest != '0 && wbFwd.dest == exMem.rt) ? wbFwd.data
                                                                 : exMem.storeData;
        laneShift = {exMem.aluResult[1:0], 3'b000};

        case (exMem.memOp)
            MemWord:            laneMask = 4'b1111;
            MemHalfS, MemHalfU: laneMask = 4'b0011;
            MemByteS, MemByteU: laneMask = 4'b0001;
            default:            laneMask = 4'b0000;
        endcase

        busReq.pc     = exMem.pc;
        busReq.addr   = exMem.aluResult;
        busReq.wData  = storeVal << laneShift;
        busReq.byteEn = exMem.store ? laneMask << exMem.aluResult[1:0] : 4'b0000;

        // Addressed byte or half moved down to bit 0
        loadShift = brRData >> laneShift;
        case (exMem.memOp)
            MemWord:  loadVal = brRData;
            MemHalfS: loadVal = {{16{loadShift[15]}}, loadShift[15:0]};
            MemHalfU: loadVal = {16'h0000, loadShift[15:0]};
            MemByteS: loadVal = {{24{loadShift[7]}}, loadShift[7:0]};
            MemByteU: loadVal = {24'h000000, loadShift[7:0]};
            default:  loadVal = exMem.result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.dest <= exMem.dest;
            wb.data <= loadVal;
        end
    end

endmodule

`default_nettype wire

// File: pipePkg.sv
// ALU and memory operation codes, result timing counts
// Pipeline register structs and the data bus request
`default_nettype none

package pipePkg;
    import isaPkg::*;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluSlt, AluSll, AluLui
    } aluOpT;

    typedef enum logic [2:0] {
        MemNone, MemWord, MemHalfS, MemHalfU, MemByteS, MemByteU
    } memOpT;

    typedef logic [1:0] timeT;

    // Produce times, counted from the execute register
    localparam timeT TimeNow  = 2'd0;
    localparam timeT TimeAlu  = 2'd1;
    localparam timeT TimeLoad = 2'd2;

    // Use times, counted from decode
    localparam timeT UseBranch = 2'd0;
    localparam timeT UseAlu    = 2'd1;
    localparam timeT UseStore  = 2'd2;
    localparam timeT UseNone   = 2'd3;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
    } ifIdRegT;

    typedef struct packed {
        logic [31:0]             pc;
        aluOpT                   aluOp;
        logic [31:0]             opA;
        logic [31:0]             opB;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic                    immSel;
        logic [31:0]             imm;
        logic [ShamtWidth-1:0]   shamt;
        memOpT                   memOp;
        logic                    store;
        logic [RegAddrWidth-1:0] dest;
        logic [31:0]             early;
        timeT                    tNew;
    } idExRegT;

    typedef struct packed {
        logic [31:0]             pc;
        logic [31:0]             aluResult;
        logic [31:0]             storeData;
        logic [RegAddrWidth-1:0] rt;
        memOpT                   memOp;
        logic                    store;
        logic [RegAddrWidth-1:0] dest;
        logic [31:0]             result;
        timeT                    tNew;
    } exMemRegT;

    typedef struct packed {
        logic [RegAddrWidth-1:0] dest;
        logic [31:0]             data;
    } memWbRegT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] wData;
        logic [3:0]  byteEn;
    } busReqT;

endpackage

`default_nettype wire

// File: registerFile.sv
// General register file, registers 1 to 31
// Same-cycle write bypass to both read ports
`timescale 1ns/10ps
`default_nettype none

module registerFile import isaPkg::*, pipePkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [RegAddrWidth-1:0] rdAddr1,
    input  logic [RegAddrWidth-1:0] rdAddr2,
    output logic [31:0]             rdData1,
    output logic [31:0]             rdData2,
    input  memWbRegT                wb
);

    logic [31:0] regs [1:31];

    function automatic logic [31:0] readPort(input logic [RegAddrWidth-1:0] addr);
        if (addr == '0) begin
            return 32'd0;
        end else if (addr == wb.dest) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdData1 = readPort(rdAddr1);
        rdData2 = readPort(rdAddr2);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

endmodule

`default_nettype wire

// File: tb_cpu.sv
// Testbench for the pipelined core
// Instruction and data memory models, test loader, bus store checker
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;

    localparam int ClkPeriod = 8;
    localparam int Budget = 200;
    localparam int MaxTests = 8;
    localparam int MaxRecords = 32;
    localparam logic [31:0] StartPc = 32'h0000_3000;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  byteEn;
    } storeRecT;

    logic        clk;
    logic        reset;
    logic [31:0] pc;
    logic [31:0] brPc;
    logic [31:0] brAddr;
    logic [31:0] brWData;
    logic [3:0]  brWe;
    logic [31:0] brRData;
    logic [31:0] imPc;
    logic [31:0] imCode;

    logic [31:0] imem [0:1023];
    logic [31:0] dmem [0:1023];
    logic [31:0] tdata [0:511];
    storeRecT    expected [0:MaxRecords-1];
    int          recCount;
    int          recNext;
    int          testErrors;
    int          errorCount;
    int          passCount;
    int          failCount;
    int          numTests;
    logic        loaded;

    cpu u_cpu (
        .clk(clk), .reset(reset), .pc(pc), .brPc(brPc), .brAddr(brAddr),
        .brWData(brWData), .brWe(brWe), .brRData(brRData),
        .imPc(imPc), .imCode(imCode)
    );

    // Both memories answer in the same cycle
    assign imCode  = imem[imPc[11:2]];
    assign brRData = dmem[brAddr[11:2]];

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] laneMask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    // Instruction at a store pc must be sw, sh or sb matching the byte enables
    function automatic logic storeAt(input logic [31:0] addr, input logic [3:0] be);
        logic [5:0] op;
        op = imem[addr[11:2]][31:26];
        case (be)
            4'b1111:                            return op == 6'h2b;
            4'b0011, 4'b1100:                   return op == 6'h29;
            4'b0001, 4'b0010, 4'b0100, 4'b1000: return op == 6'h28;
            default:                            return 1'b0;
        endcase
    endfunction

    // Store checker and data memory write port
    always @(posedge clk) begin
        if (!reset && brWe != 4'b0000) begin
            if (!storeAt(brPc, brWe) || !storeAt(pc, brWe)) begin
                $display("error at %0t: bus write from pc %h, memory pc %h, is no matching store",
                         $time, brPc, pc);
                testErrors++;
                errorCount++;
            end
            if (recNext >= recCount) begin
                $display("error at %0t: unexpected store to %h", $time, brAddr);
                testErrors++;
                errorCount++;
            end else begin
                if (brAddr !== expected[recNext].addr
                    || brWe !== expected[recNext].byteEn
                    || (brWData & laneMask(brWe)) !==
                       (expected[recNext].data & laneMask(expected[recNext].byteEn))) begin
                    $display("error at %0t: store %0d got %h %h %b, expected %h %h %b",
                             $time, recNext, brAddr, brWData, brWe,
                             expected[recNext].addr, expected[recNext].data,
                             expected[recNext].byteEn);
                    testErrors++;
                    errorCount++;
                end
                recNext++;
            end
            for (int b = 0; b < 4; b++) begin
                if (brWe[b]) begin
                    dmem[brAddr[11:2]][b*8 +: 8] <= brWData[b*8 +: 8];
                end
            end
        end
    end

    task automatic checkResetState();
        if (brWe !== 4'b0000 || imPc !== StartPc) begin
            $display("error at %0t: reset state wrong, imPc %h brWe %b", $time, imPc, brWe);
            testErrors++;
            errorCount++;
        end
    endtask

    task automatic runTest(inout int ptr);
        int name;
        int nProg;
        int cycles;
        // Core held in reset while the memories are reloaded
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);

        name  = tdata[ptr];
        nProg = tdata[ptr + 1];
        recCount = 0;
        recNext = 0;
        testErrors = 0;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = 32'h0000_0000;
            dmem[i] = 32'h5a5a_0000 ^ (i * 32'h0001_0104);
        end
        for (int i = 0; i < nProg; i++) begin
            imem[i] = tdata[ptr + 3 + i];
        end
        for (int r = 0; r < tdata[ptr + 2] && r < MaxRecords; r++) begin
            expected[r].addr   = tdata[ptr + 3 + nProg + 3 * r];
            expected[r].data   = tdata[ptr + 4 + nProg + 3 * r];
            expected[r].byteEn = tdata[ptr + 5 + nProg + 3 * r];
            recCount++;
        end
        ptr = ptr + 3 + nProg + 3 * tdata[ptr + 2];

        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            if (k == 2) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            checkResetState();
        end

        cycles = 0;
        while (recNext < recCount && cycles < Budget) begin
            @(negedge clk);
            cycles++;
        end
        if (recNext < recCount) begin
            $display("test %0d did not finish: missing stores", name);
            testErrors++;
            errorCount++;
        end
        if (testErrors == 0) begin
            passCount++;
            $display("test %0d ok: %0d stores in %0d cycles", name, recCount, cycles);
        end else begin
            failCount++;
            $display("test %0d failed with %0d errors", name, testErrors);
        end
    endtask

    initial begin
        watchdogTimer();
    end

    task automatic watchdogTimer();
        wait (loaded);
        #((numTests * (Budget + 10) * ClkPeriod) + 1000);
        $display("watchdog expired: simulation did not finish in time");
        $display("TB FAILED");
        $finish;
    endtask

    initial begin
        int ptr;
        reset = 1'b1;
        loaded = 1'b0;
        recCount = 0;
        recNext = 0;
        testErrors = 0;
        errorCount = 0;
        passCount = 0;
        failCount = 0;
        $readmemh("cpu_testdata.txt", tdata);
        numTests = tdata[0];
        if (numTests < 1 || numTests > MaxTests) begin
            $display("test data file missing or holds a bad test count");
            numTests = 0;
            failCount++;
        end
        loaded = 1'b1;
        ptr = 1;
        for (int t = 0; t < numTests; t++) begin
            runTest(ptr);
        end
        $display("tests passed %0d failed %0d errors %0d", passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
isaPkg.sv
pipePkg.sv
fetchStage.sv
decodeStage.sv
registerFile.sv
executeStage.sv
memoryStage.sv
hazardControl.sv
cpu.sv
tb_cpu.sv
